//--- rtl/apd_hv_config.svh
// constants for the apd high-voltage compensation loop
// adc to temperature gain and offset, device temperature offset,
// dac code after reset, compensation table depth
`ifndef APD_HV_CONFIG_SVH
`define APD_HV_CONFIG_SVH

// ----------------------------------------
// temperature conversion
// ----------------------------------------
// adc code to Q8.8 multiplier
`define TEMP_GAIN        16
// 20.0 degrees in Q8.8, removed after the multiply
`define TEMP_OFFSET_Q88  16'h1400
// whole degrees between table base and device temperature
`define TEMP_MASK_OFFSET 20

// ----------------------------------------
// dac and table
// ----------------------------------------
// 12-bit code held until the first request completes
`define DAC_RESET_CODE   204
// entries in the hvcp table
`define HVCP_DEPTH       128

`endif

//--- rtl/apd_hv_pkg.sv
// shared types for the apd high-voltage compensation loop
// vector typedefs for codes, temperatures and table words
// state encoding of the request sequencer
`default_nettype none
`include "apd_hv_config.svh"

package apd_hv_pkg;

	// ----------------------------------------
	// data vectors
	// ----------------------------------------
	// 10-bit adc input with two zero lsbs appended
	typedef logic [11:0] adc_code_t;
	// signed-free Q8.8 temperature
	typedef logic [15:0] temp_q88_t;
	// integer part of the temperature
	typedef logic [7:0]  temp_deg_t;
	// internal dac code, top 10 bits leave the block
	typedef logic [11:0] dac_code_t;
	// table index and table word
	typedef logic [$clog2(`HVCP_DEPTH)-1:0] hvcp_addr_t;
	typedef logic [15:0] hvcp_word_t;

	// sequencer states, idle zero and one-hot otherwise
	typedef enum logic [7:0] {
		DAC_IDLE     = 8'b0000_0000,
		DAC_TEMP_NOW = 8'b0000_0010,
		DAC_CHOOSE   = 8'b0000_0100,
		DAC_PARA     = 8'b0000_1000,
		DAC_ASSIGN   = 8'b0001_0000,
		DAC_VALUE    = 8'b0010_0000,
		DAC_END      = 8'b0100_0000
	} dac_state_t;

endpackage

`default_nettype wire

//--- rtl/apd_hv_ifs.sv
// internal handshake bundles of the compensation loop
// temp_conv_if   sequencer to adc-to-temperature converter
// hvcp_lookup_if sequencer to compensation table lookup
`timescale 1ns/1ns
`default_nettype none

// start pulse carries the code, done pulses 3 cycles later
interface temp_conv_if;
	import apd_hv_pkg::*;

	logic      start;
	adc_code_t adc_code;
	logic      done;
	temp_q88_t temp_value;

	modport seq  (output start, adc_code, input  done, temp_value);
	modport conv (input  start, adc_code, output done, temp_value);
endinterface

// start pulse, done with dac_para 3 cycles later
interface hvcp_lookup_if;
	import apd_hv_pkg::*;

	logic      start;
	temp_deg_t apd_temp;
	temp_deg_t temp_base;
	logic      done;
	dac_code_t dac_para;

	modport seq (output start, apd_temp, temp_base, input  done, dac_para);
	// table side of the lookup
	modport tbl (input  start, apd_temp, temp_base, output done, dac_para);
endinterface

`default_nettype wire

//--- rtl/adc_to_temp.sv
// adc code to Q8.8 temperature converter
// stage 1 capture, stage 2 gain multiply,
// stage 3 offset subtract with saturation at zero and full scale
`timescale 1ns/1ns
`default_nettype none
`include "apd_hv_config.svh"

module adc_to_temp (
	input  wire       i_clk_50m,
	input  wire       i_rst_n,
	temp_conv_if.conv conv
);
	import apd_hv_pkg::*;

	// product width, room for gains up to 8 bits
	localparam int PROD_W = 20;

	adc_code_t         r_code;
	logic [PROD_W-1:0] r_prod;
	logic [PROD_W-1:0] w_diff;
	temp_q88_t         r_temp;
	// one valid bit per stage
	logic [2:0]        r_valid;

	// ----------------------------------------
	// valid shift register
	// ----------------------------------------
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_valid <= 3'b000;
		end else begin
			r_valid <= {r_valid[1:0], conv.start};
		end
	end

	// ----------------------------------------
	// data pipeline
	// ----------------------------------------
	// offset removed from the product
	assign w_diff = r_prod - PROD_W'(`TEMP_OFFSET_Q88);

	always_ff @(posedge i_clk_50m) begin
		// code only sampled with the start pulse
		if (conv.start) begin
			r_code <= conv.adc_code;
		end
		if (r_valid[0]) begin
			r_prod <= PROD_W'(r_code) * PROD_W'(`TEMP_GAIN);
		end
		// below offset clamps to 0.0, overflow to max
		if (r_valid[1]) begin
			if (r_prod < PROD_W'(`TEMP_OFFSET_Q88)) begin
				r_temp <= '0;
			end else if (w_diff[PROD_W-1:16] != '0) begin
				r_temp <= '1;
			end else begin
				r_temp <= w_diff[15:0];
			end
		end
	end

	assign conv.done       = r_valid[2];
	assign conv.temp_value = r_temp;

endmodule

`default_nettype wire

//--- rtl/dac_table.sv
// compensation table lookup
// signed temperature difference clamped to the table range,
// registered ram read, captured entry returned as dac parameter
`timescale 1ns/1ns
`default_nettype none
`include "apd_hv_config.svh"

module dac_table (
	input  wire                         i_clk_50m,
	input  wire                         i_rst_n,
	hvcp_lookup_if.tbl                  lk,
	output apd_hv_pkg::hvcp_addr_t      o_hvcp_ram_rdaddr,
	input  wire apd_hv_pkg::hvcp_word_t i_hvcp_rddata
);
	import apd_hv_pkg::*;

	// one extra bit for the sign of the difference
	localparam int DIFF_W = $bits(temp_deg_t) + 1;

	logic signed [DIFF_W-1:0] w_diff;
	hvcp_addr_t               r_addr;
	dac_code_t                r_para;
	// address, ram wait, capture
	logic [2:0]               r_valid;

	// ----------------------------------------
	// index forming
	// ----------------------------------------
	// both operands unsigned degrees, result signed
	assign w_diff = $signed({1'b0, lk.apd_temp}) - $signed({1'b0, lk.temp_base});

	always_ff @(posedge i_clk_50m) begin
		if (lk.start) begin
			// colder than the table base
			if (w_diff < 0) begin
				r_addr <= '0;
			// hotter than the last entry
			end else if (w_diff > $signed(DIFF_W'(`HVCP_DEPTH - 1))) begin
				r_addr <= hvcp_addr_t'(`HVCP_DEPTH - 1);
			end else begin
				r_addr <= hvcp_addr_t'(w_diff);
			end
		end
		// ram data lands one cycle after the address
		if (r_valid[1]) begin
			r_para <= i_hvcp_rddata[11:0];
		end
	end

	// ----------------------------------------
	// handshake
	// ----------------------------------------
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_valid <= 3'b000;
		end else begin
			r_valid <= {r_valid[1:0], lk.start};
		end
	end

	assign o_hvcp_ram_rdaddr = r_addr;
	assign lk.done           = r_valid[2];
	assign lk.dac_para       = r_para;

endmodule

`default_nettype wire

//--- rtl/adc_to_dac.sv
// request sequencer of the compensation loop
// temperature measurement, table or direct dac code selection,
// dac value and device temperature outputs
`timescale 1ns/1ns
`default_nettype none
`include "apd_hv_config.svh"

module adc_to_dac (
	input  wire                         i_clk_50m,
	input  wire                         i_rst_n,
	input  wire                         i_dac_set_sig,
	input  wire [9:0]                   i_adc_temp_value,
	input  wire [15:0]                  i_temp_apdhv_base,
	input  wire [15:0]                  i_temp_temp_base,
	input  wire                         i_hvcp_switch,
	output apd_hv_pkg::hvcp_addr_t      o_hvcp_ram_rdaddr,
	input  wire apd_hv_pkg::hvcp_word_t i_hvcp_rddata,
	output logic                        o_dac_start,
	output logic [9:0]                  o_dac_value,
	output apd_hv_pkg::temp_deg_t       o_device_temp
);
	import apd_hv_pkg::*;

	dac_state_t r_state;
	adc_code_t  r_adc_code;
	logic       r_temp_start;
	temp_q88_t  r_apd_temp;
	logic       r_para_start;
	dac_code_t  r_dac_value;

	temp_conv_if   u_conv_if ();
	hvcp_lookup_if u_lk_if ();

	// ----------------------------------------
	// state machine
	// ----------------------------------------
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state <= DAC_IDLE;
		end else begin
			case (r_state)
				// requests only accepted here
				DAC_IDLE:     if (i_dac_set_sig) r_state <= DAC_TEMP_NOW;
				DAC_TEMP_NOW: if (u_conv_if.done) r_state <= DAC_CHOOSE;
				DAC_CHOOSE:   r_state <= i_hvcp_switch ? DAC_PARA : DAC_VALUE;
				DAC_PARA:     r_state <= DAC_ASSIGN;
				DAC_ASSIGN:   if (u_lk_if.done) r_state <= DAC_END;
				DAC_VALUE:    r_state <= DAC_END;
				DAC_END:      r_state <= DAC_IDLE;
				default:      r_state <= DAC_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// control pulses and result registers
	// ----------------------------------------
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_temp_start <= 1'b0;
			r_para_start <= 1'b0;
			r_apd_temp   <= '0;
			r_dac_value  <= dac_code_t'(`DAC_RESET_CODE);
		end else begin
			// single pulse in the first TEMP_NOW cycle
			r_temp_start <= (r_state == DAC_IDLE) && i_dac_set_sig;
			// lookup starts in the first ASSIGN cycle
			r_para_start <= (r_state == DAC_PARA);
			if ((r_state == DAC_TEMP_NOW) && u_conv_if.done) begin
				r_apd_temp <= u_conv_if.temp_value;
			end
			// direct mode takes the base voltage code as is
			if (r_state == DAC_VALUE) begin
				r_dac_value <= i_temp_apdhv_base[11:0];
			end else if ((r_state == DAC_ASSIGN) && u_lk_if.done) begin
				r_dac_value <= u_lk_if.dac_para;
			end
		end
	end

	// adc sample taken when the request is accepted
	always_ff @(posedge i_clk_50m) begin
		if ((r_state == DAC_IDLE) && i_dac_set_sig) begin
			r_adc_code <= {i_adc_temp_value, 2'b00};
		end
	end

	// ----------------------------------------
	// sub-block connections
	// ----------------------------------------
	assign u_conv_if.start     = r_temp_start;
	assign u_conv_if.adc_code  = r_adc_code;
	assign u_lk_if.start       = r_para_start;
	assign u_lk_if.apd_temp    = r_apd_temp[15:8];
	// table base shifted by the mask offset
	assign u_lk_if.temp_base   = i_temp_temp_base[7:0] + 8'(`TEMP_MASK_OFFSET);

	adc_to_temp u_adc_to_temp (
		.i_clk_50m (i_clk_50m),
		.i_rst_n   (i_rst_n),
		.conv      (u_conv_if.conv)
	);

	dac_table u_dac_table (
		.i_clk_50m         (i_clk_50m),
		.i_rst_n           (i_rst_n),
		.lk                (u_lk_if.tbl),
		.o_hvcp_ram_rdaddr (o_hvcp_ram_rdaddr),
		.i_hvcp_rddata     (i_hvcp_rddata)
	);

	// start marks the end of a request, value already settled
	assign o_dac_start   = (r_state == DAC_END);
	assign o_dac_value   = r_dac_value[11:2];
	assign o_device_temp = r_apd_temp[15:8] - 8'(`TEMP_MASK_OFFSET);

endmodule

`default_nettype wire

//--- rtl/hvcp_ram.sv
// hvcp compensation table storage
// wishbone classic slave for host load and readback,
// separate registered read port for the table lookup
`timescale 1ns/1ns
`default_nettype none
`include "apd_hv_config.svh"

module hvcp_ram (
	input  wire                         i_clk_50m,
	input  wire                         i_rst_n,
	input  wire                         i_wb_cyc,
	input  wire                         i_wb_stb,
	input  wire                         i_wb_we,
	input  wire apd_hv_pkg::hvcp_addr_t i_wb_adr,
	input  wire apd_hv_pkg::hvcp_word_t i_wb_dat,
	output apd_hv_pkg::hvcp_word_t      o_wb_dat,
	output logic                        o_wb_ack,
	input  wire apd_hv_pkg::hvcp_addr_t i_rd_addr,
	output apd_hv_pkg::hvcp_word_t      o_rd_data
);
	import apd_hv_pkg::*;

	hvcp_word_t mem [0:`HVCP_DEPTH-1];
	logic       w_wb_req;

	// ----------------------------------------
	// wishbone slave
	// ----------------------------------------
	// new cycle seen, masked during ack so acks never run back to back
	assign w_wb_req = i_wb_cyc && i_wb_stb && !o_wb_ack;

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_wb_ack <= 1'b0;
		end else begin
			o_wb_ack <= w_wb_req;
		end
	end

	always_ff @(posedge i_clk_50m) begin
		if (w_wb_req && i_wb_we) begin
			mem[i_wb_adr] <= i_wb_dat;
		end
		// read data valid together with ack
		if (w_wb_req) begin
			o_wb_dat <= mem[i_wb_adr];
		end
		// lookup port, one cycle latency
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

`default_nettype wire

//--- rtl/apd_hv_comp_top.sv
// apd high-voltage temperature compensation top level
// request sequencer with its converter and lookup,
// hvcp table ram with the host wishbone port
`timescale 1ns/1ns
`default_nettype none

module apd_hv_comp_top (
	input  wire                         i_clk_50m,
	input  wire                         i_rst_n,
	// compensation request
	input  wire                         i_dac_set_sig,
	input  wire [9:0]                   i_adc_temp_value,
	input  wire [15:0]                  i_temp_apdhv_base,
	input  wire [15:0]                  i_temp_temp_base,
	input  wire                         i_hvcp_switch,
	// dac result
	output logic                        o_dac_start,
	output logic [9:0]                  o_dac_value,
	output apd_hv_pkg::temp_deg_t       o_device_temp,
	// host table access
	input  wire                         i_wb_cyc,
	input  wire                         i_wb_stb,
	input  wire                         i_wb_we,
	input  wire apd_hv_pkg::hvcp_addr_t i_wb_adr,
	input  wire apd_hv_pkg::hvcp_word_t i_wb_dat,
	output apd_hv_pkg::hvcp_word_t      o_wb_dat,
	output logic                        o_wb_ack
);
	import apd_hv_pkg::*;

	// table read pair between lookup and ram
	hvcp_addr_t w_hvcp_rdaddr;
	hvcp_word_t w_hvcp_rddata;

	adc_to_dac u_adc_to_dac (
		.i_clk_50m         (i_clk_50m),
		.i_rst_n           (i_rst_n),
		.i_dac_set_sig     (i_dac_set_sig),
		.i_adc_temp_value  (i_adc_temp_value),
		.i_temp_apdhv_base (i_temp_apdhv_base),
		.i_temp_temp_base  (i_temp_temp_base),
		.i_hvcp_switch     (i_hvcp_switch),
		.o_hvcp_ram_rdaddr (w_hvcp_rdaddr),
		.i_hvcp_rddata     (w_hvcp_rddata),
		.o_dac_start       (o_dac_start),
		.o_dac_value       (o_dac_value),
		.o_device_temp     (o_device_temp)
	);

	hvcp_ram u_hvcp_ram (
		.i_clk_50m (i_clk_50m),
		.i_rst_n   (i_rst_n),
		.i_wb_cyc  (i_wb_cyc),
		.i_wb_stb  (i_wb_stb),
		.i_wb_we   (i_wb_we),
		.i_wb_adr  (i_wb_adr),
		.i_wb_dat  (i_wb_dat),
		.o_wb_dat  (o_wb_dat),
		.o_wb_ack  (o_wb_ack),
		.i_rd_addr (w_hvcp_rdaddr),
		.o_rd_data (w_hvcp_rddata)
	);

endmodule

`default_nettype wire

//--- verification/tb_apd_hv_comp.sv
// testbench for the apd high-voltage compensation top level
// wishbone load and readback of the hvcp table,
// request table in direct and table mode against a reference model,
// rejection of a request while the sequencer is busy
`timescale 1ns/1ns
`default_nettype none
`include "apd_hv_config.svh"

module tb_apd_hv_comp;
	import apd_hv_pkg::*;

	localparam int WB_TIMEOUT  = 16;
	localparam int REQ_TIMEOUT = 64;
	localparam int N_REQ       = 8;

	typedef struct packed {
		logic [9:0]  adc;
		logic        sw;
		logic [15:0] apdhv;
		logic [15:0] tbase;
	} req_t;

	// adc code, switch, apdhv base, temp base
	req_t req_tab [0:N_REQ-1] = '{
		'{10'd400,  1'b0, 16'h0abc, 16'h0010},
		'{10'd400,  1'b1, 16'h0000, 16'h001e},
		'{10'd300,  1'b1, 16'h0000, 16'h0000},
		// colder than the table base
		'{10'd10,   1'b1, 16'h0000, 16'h000a},
		// hotter than the last entry
		'{10'd1023, 1'b1, 16'h0000, 16'h0000},
		'{10'd512,  1'b1, 16'h0000, 16'h0019},
		'{10'd0,    1'b0, 16'hffff, 16'h0000},
		// base plus offset wraps past 255
		'{10'd140,  1'b1, 16'h0000, 16'hffec}
	};

	logic       i_clk_50m;
	logic       i_rst_n;
	logic       i_dac_set_sig;
	logic [9:0] i_adc_temp_value;
	logic [15:0] i_temp_apdhv_base;
	logic [15:0] i_temp_temp_base;
	logic       i_hvcp_switch;
	logic       o_dac_start;
	logic [9:0] o_dac_value;
	temp_deg_t  o_device_temp;
	logic       i_wb_cyc;
	logic       i_wb_stb;
	logic       i_wb_we;
	hvcp_addr_t i_wb_adr;
	hvcp_word_t i_wb_dat;
	hvcp_word_t o_wb_dat;
	logic       o_wb_ack;

	// host-side copy of the table contents
	hvcp_word_t model_mem [0:`HVCP_DEPTH-1];
	int         err_count;
	int         test_err;
	int         tests_run;
	int         tests_failed;
	integer     seed;

	apd_hv_comp_top apd_hv_comp_top_i (
		.i_clk_50m (i_clk_50m), .i_rst_n (i_rst_n),
		.i_dac_set_sig (i_dac_set_sig), .i_adc_temp_value (i_adc_temp_value),
		.i_temp_apdhv_base (i_temp_apdhv_base), .i_temp_temp_base (i_temp_temp_base),
		.i_hvcp_switch (i_hvcp_switch), .o_dac_start (o_dac_start),
		.o_dac_value (o_dac_value), .o_device_temp (o_device_temp),
		.i_wb_cyc (i_wb_cyc), .i_wb_stb (i_wb_stb), .i_wb_we (i_wb_we),
		.i_wb_adr (i_wb_adr), .i_wb_dat (i_wb_dat),
		.o_wb_dat (o_wb_dat), .o_wb_ack (o_wb_ack)
	);

	// 50 MHz
	initial begin
		i_clk_50m = 1'b0;
		forever #10 i_clk_50m = ~i_clk_50m;
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	// code x gain minus 20.0, floored at zero
	function automatic temp_q88_t model_temp_q88(input logic [9:0] adc);
		int prod;
		prod = int'({adc, 2'b00}) * `TEMP_GAIN - int'(`TEMP_OFFSET_Q88);
		if (prod < 0) return '0;
		if (prod > 65535) return 16'hffff;
		return 16'(prod);
	endfunction

	// signed offset from the 8-bit table base, clamped to the table
	function automatic hvcp_addr_t model_index(input temp_deg_t deg, input logic [15:0] tbase);
		int base;
		int diff;
		base = (int'(tbase[7:0]) + `TEMP_MASK_OFFSET) % 256;
		diff = int'(deg) - base;
		if (diff < 0) return '0;
		if (diff > `HVCP_DEPTH - 1) return hvcp_addr_t'(`HVCP_DEPTH - 1);
		return hvcp_addr_t'(diff);
	endfunction

	// ----------------------------------------
	// checks and bus tasks
	// ----------------------------------------
	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			err_count++;
			test_err++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("%s", msg);
		err_count++;
		test_err++;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_err == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, test_err);
			tests_failed++;
		end
		test_err = 0;
	endtask

	// all tasks start and end 2 ns after a rising edge
	task automatic wb_write(input hvcp_addr_t addr, input hvcp_word_t data);
		int n;
		n = 0;
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we  = 1'b1;
		i_wb_adr = addr;
		i_wb_dat = data;
		do begin
			@(posedge i_clk_50m);
			#2;
			n++;
		end while (!o_wb_ack && n < WB_TIMEOUT);
		if (!o_wb_ack) report_error($sformatf("no wishbone ack on write to index %0d", addr));
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we  = 1'b0;
	endtask

	task automatic wb_read(input hvcp_addr_t addr, output hvcp_word_t data);
		int n;
		n = 0;
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we  = 1'b0;
		i_wb_adr = addr;
		do begin
			@(posedge i_clk_50m);
			#2;
			n++;
		end while (!o_wb_ack && n < WB_TIMEOUT);
		if (!o_wb_ack) report_error($sformatf("no wishbone ack on read of index %0d", addr));
		// read data only valid with ack
		data = o_wb_dat;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
	endtask

	// one-cycle request pulse, then wait for the dac start pulse
	task automatic apply_request(input req_t r);
		int n;
		n = 0;
		i_adc_temp_value  = r.adc;
		i_hvcp_switch     = r.sw;
		i_temp_apdhv_base = r.apdhv;
		i_temp_temp_base  = r.tbase;
		i_dac_set_sig     = 1'b1;
		@(posedge i_clk_50m);
		#2;
		i_dac_set_sig = 1'b0;
		while (!o_dac_start && n < REQ_TIMEOUT) begin
			@(posedge i_clk_50m);
			#2;
			n++;
		end
		if (!o_dac_start) report_error("request never produced a dac start pulse");
		// sequencer back in idle one cycle after the start pulse
		@(posedge i_clk_50m);
		#2;
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		hvcp_word_t  rd;
		logic [31:0] rnd;
		temp_q88_t   exp_q88;
		temp_deg_t   exp_deg;
		temp_deg_t   exp_dev;
		logic [9:0]  exp_dac;
		int          pulses;
		err_count = 0;
		test_err = 0;
		tests_run = 0;
		tests_failed = 0;
		seed = 32'h8a4b;
		i_rst_n = 1'b0;
		i_dac_set_sig = 1'b0;
		i_adc_temp_value = '0;
		i_temp_apdhv_base = '0;
		i_temp_temp_base = '0;
		i_hvcp_switch = 1'b0;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		repeat (4) @(posedge i_clk_50m);
		#2;
		i_rst_n = 1'b1;

		// 204 >> 2 on the dac, 0 - 20 on the device temperature
		check_value("o_dac_start", 32'(o_dac_start), 32'h0);
		check_value("o_wb_ack", 32'(o_wb_ack), 32'h0);
		check_value("o_dac_value", 32'(o_dac_value), 32'd51);
		check_value("o_device_temp", 32'(o_device_temp), 32'hec);
		end_test("reset state");

		// pattern over the full index, then a few random overwrites
		for (int i = 0; i < `HVCP_DEPTH; i++) begin
			model_mem[i] = 16'h0100 + 16'(i * 8);
			wb_write(hvcp_addr_t'(i), model_mem[i]);
		end
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			model_mem[rnd[6:0]] = rnd[31:16];
			wb_write(rnd[6:0], rnd[31:16]);
		end
		for (int i = 0; i < `HVCP_DEPTH; i++) begin
			wb_read(hvcp_addr_t'(i), rd);
			check_value($sformatf("o_wb_dat[%0d]", i), 32'(rd), 32'(model_mem[i]));
		end
		end_test("table load and readback");

		for (int k = 0; k < N_REQ; k++) begin
			apply_request(req_tab[k]);
			exp_q88 = model_temp_q88(req_tab[k].adc);
			exp_deg = exp_q88[15:8];
			exp_dev = exp_deg - 8'(`TEMP_MASK_OFFSET);
			if (req_tab[k].sw) begin
				exp_dac = model_mem[model_index(exp_deg, req_tab[k].tbase)][11:2];
			end else begin
				exp_dac = req_tab[k].apdhv[11:2];
			end
			check_value("o_dac_value", 32'(o_dac_value), 32'(exp_dac));
			check_value("o_device_temp", 32'(o_device_temp), 32'(exp_dev));
			end_test($sformatf("request %0d, %s mode", k, req_tab[k].sw ? "table" : "direct"));
		end

		// second pulse lands while the first request converts
		i_adc_temp_value = 10'd200;
		i_hvcp_switch = 1'b0;
		i_temp_apdhv_base = 16'h0123;
		i_temp_temp_base = 16'h0000;
		i_dac_set_sig = 1'b1;
		pulses = 0;
		for (int k = 1; k <= 40; k++) begin
			@(posedge i_clk_50m);
			#2;
			i_dac_set_sig = (k == 3);
			if (o_dac_start) pulses++;
		end
		check_value("o_dac_start pulses", 32'(pulses), 32'd1);
		check_value("o_dac_value", 32'(o_dac_value), 32'h048);
		end_test("busy request ignored");

		$display("tests run %0d, tests failed %0d, mismatches %0d",
			tests_run, tests_failed, err_count);
		if (err_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- apd_hv_comp_top.f
+incdir+rtl
rtl/apd_hv_pkg.sv
rtl/apd_hv_ifs.sv
rtl/adc_to_temp.sv
rtl/dac_table.sv
rtl/adc_to_dac.sv
rtl/hvcp_ram.sv
rtl/apd_hv_comp_top.sv
verification/tb_apd_hv_comp.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the compensation loop testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
	--top-module tb_apd_hv_comp \
	-f apd_hv_comp_top.f \
	-o tb_apd_hv_comp
./obj_dir/tb_apd_hv_comp | tee sim.log

if grep -q "TB FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
